// ==== rd_mux_pkg.sv ====
package rd_mux_pkg;

    // addressed subordinate count
    localparam int unsigned NUM_SUB = 6;
    // ports incl. default subordinate
    localparam int unsigned NUM_PORT = 7;
    // default port sits at the last index
    localparam int unsigned DEFAULT_SUB = 6;
    localparam int unsigned NUM_MGR = 2;

    // id widths, subordinate side carries the extra manager field
    localparam int unsigned SUB_ID_W = 8;
    localparam int unsigned MGR_ID_W = 4;
    localparam int unsigned DATA_W = 32;

    // manager field inside the subordinate-side id
    localparam int unsigned MGR_FIELD_LSB = 4;
    localparam int unsigned MGR_FIELD_W = 2;
    typedef logic [MGR_FIELD_W-1:0] mgr_field_t;
    localparam mgr_field_t MGR0_CODE = 2'b01;
    localparam mgr_field_t MGR1_CODE = 2'b10;

    // highest priority first
    localparam int unsigned SUB_PRIORITY [NUM_SUB] = '{2, 3, 1, 4, 0, 5};

    typedef logic [SUB_ID_W-1:0] sub_id_t;
    typedef logic [MGR_ID_W-1:0] mgr_id_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [1:0] resp_t;

    typedef logic [NUM_SUB-1:0] pend_vec_t;
    typedef logic [NUM_PORT-1:0] port_vec_t;
    typedef logic [NUM_MGR-1:0] mgr_vec_t;

    // one read beat at a subordinate port
    typedef struct packed {
        sub_id_t id;
        data_t   data;
        resp_t   resp;
        logic    last;
    } r_beat_t;

    // same beat after the manager field is stripped
    typedef struct packed {
        mgr_id_t id;
        data_t   data;
        resp_t   resp;
        logic    last;
    } m_beat_t;

endpackage

// ==== rd_pending_track.sv ====
`timescale 1ns/1ps

module rd_pending_track (
    input  logic                  clk,
    input  logic                  rst,
    // address accepted toward each subordinate
    input  rd_mux_pkg::pend_vec_t ar_valid,
    // last beat of that subordinate handed off
    input  rd_mux_pkg::pend_vec_t beat_done,
    output rd_mux_pkg::pend_vec_t pending
);

    import rd_mux_pkg::*;

    pend_vec_t pending_q;

    // one flag per addressed subordinate
    // a flag means a read burst is still owed by that subordinate
    // default port has no flag, it is only the fallback
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= '0;
        end else begin
            for (int i = 0; i < NUM_SUB; i++) begin
                // set has priority over clear
                if (ar_valid[i]) begin
                    pending_q[i] <= 1'b1;
                end else if (beat_done[i]) begin
                    pending_q[i] <= 1'b0;
                end
            end
        end
    end

    // selection follows the registered flags only,
    // so a burst cannot be cut off by a new address in the same cycle
    assign pending = pending_q;

endmodule

// ==== rd_sub_select.sv ====
`timescale 1ns/1ps

module rd_sub_select (
    // registered pending flags from the tracker
    input  rd_mux_pkg::pend_vec_t pending,
    // beats and valids from all ports, default included
    input  rd_mux_pkg::r_beat_t   sub_beat [rd_mux_pkg::NUM_PORT],
    input  rd_mux_pkg::port_vec_t sub_valid,
    // ready of the manager the selected beat is headed to
    input  logic                  fwd_ready,
    output rd_mux_pkg::r_beat_t   sel_beat,
    output logic                  sel_valid,
    output rd_mux_pkg::port_vec_t sub_ready,
    // last beat of the selected subordinate accepted
    output rd_mux_pkg::pend_vec_t beat_done
);

    import rd_mux_pkg::*;

    // one-hot port select
    port_vec_t sel_oh;
    // any pending subordinate found on the priority walk
    logic      hit;

    // fixed priority walk over SUB_PRIORITY
    always_comb begin
        sel_oh = '0;
        hit    = 1'b0;
        for (int p = 0; p < NUM_SUB; p++) begin
            if (!hit && pending[SUB_PRIORITY[p]]) begin
                sel_oh[SUB_PRIORITY[p]] = 1'b1;
                hit                     = 1'b1;
            end
        end
        // nothing owed, default subordinate takes the channel
        if (!hit) begin
            sel_oh[DEFAULT_SUB] = 1'b1;
        end
    end

    // beat mux, sel_oh is one-hot so at most one term matches
    always_comb begin
        sel_beat  = '0;
        sel_valid = 1'b0;
        for (int i = 0; i < NUM_PORT; i++) begin
            if (sel_oh[i]) begin
                sel_beat  = sub_beat[i];
                sel_valid = sub_valid[i];
            end
        end
    end

    // ready only back to the selected port
    // other ports see zero and hold their beats
    always_comb begin
        for (int i = 0; i < NUM_PORT; i++) begin
            sub_ready[i] = sel_oh[i] & fwd_ready;
        end
    end

    // completion of a burst
    // valid, ready and last together on the selected addressed port
    // the default port has no flag so it never reports here
    always_comb begin
        for (int i = 0; i < NUM_SUB; i++) begin
            beat_done[i] = sel_oh[i] & sub_valid[i] & fwd_ready & sub_beat[i].last;
        end
    end

endmodule

// ==== rd_mgr_route.sv ====
`timescale 1ns/1ps

module rd_mgr_route (
    // beat picked by the selector
    input  rd_mux_pkg::r_beat_t  sel_beat,
    input  logic                 sel_valid,
    input  rd_mux_pkg::mgr_vec_t mgr_ready,
    // shared by both managers, only valid differs
    output rd_mux_pkg::m_beat_t  mgr_beat,
    output logic                 fwd_ready,
    output rd_mux_pkg::mgr_vec_t mgr_valid
);

    import rd_mux_pkg::*;

    // manager field of the selected id
    mgr_field_t mgr_field;

    assign mgr_field = sel_beat.id[MGR_FIELD_LSB +: MGR_FIELD_W];

    // payload to the managers, id cut down to the manager width
    assign mgr_beat.id   = sel_beat.id[MGR_ID_W-1:0];
    assign mgr_beat.data = sel_beat.data;
    assign mgr_beat.resp = sel_beat.resp;
    assign mgr_beat.last = sel_beat.last;

    // steer valid forward and ready back by the manager field
    // valid is never gated by ready here
    always_comb begin
        mgr_valid = '0;
        fwd_ready = 1'b0;
        case (mgr_field)
            MGR0_CODE: begin
                mgr_valid[0] = sel_valid;
                fwd_ready    = mgr_ready[0];
            end
            MGR1_CODE: begin
                mgr_valid[1] = sel_valid;
                fwd_ready    = mgr_ready[1];
            end
            // 00 and 11 go nowhere
            // beat is never acked, subordinate keeps holding it
            default: begin
                mgr_valid = '0;
                fwd_ready = 1'b0;
            end
        endcase
    end

endmodule

// ==== rd_channel_mux.sv ====
`timescale 1ns/1ps

module rd_channel_mux (
    input  logic                  clk,
    input  logic                  rst,
    // address valid per addressed subordinate
    input  rd_mux_pkg::pend_vec_t ar_valid,
    // read beats from the subordinates, default port last
    input  rd_mux_pkg::r_beat_t   sub_beat [rd_mux_pkg::NUM_PORT],
    input  rd_mux_pkg::port_vec_t sub_valid,
    output rd_mux_pkg::port_vec_t sub_ready,
    // one beat, fanned out to both managers
    output rd_mux_pkg::m_beat_t   mgr_beat,
    output rd_mux_pkg::mgr_vec_t  mgr_valid,
    input  rd_mux_pkg::mgr_vec_t  mgr_ready
);

    import rd_mux_pkg::*;

    // tracker to selector
    pend_vec_t pending;
    // selector back to tracker
    pend_vec_t beat_done;
    // selector to router
    r_beat_t   sel_beat;
    logic      sel_valid;
    // router back to selector
    logic      fwd_ready;

    // pending flags, the only state in the channel
    rd_pending_track u_track (
        .clk       (clk),
        .rst       (rst),
        .ar_valid  (ar_valid),
        .beat_done (beat_done),
        .pending   (pending)
    );

    // picks one port, muxes its beat, returns ready
    rd_sub_select u_select (
        .pending   (pending),
        .sub_beat  (sub_beat),
        .sub_valid (sub_valid),
        .fwd_ready (fwd_ready),
        .sel_beat  (sel_beat),
        .sel_valid (sel_valid),
        .sub_ready (sub_ready),
        .beat_done (beat_done)
    );

    // id-based steering toward manager 0 or 1
    rd_mgr_route u_route (
        .sel_beat  (sel_beat),
        .sel_valid (sel_valid),
        .mgr_ready (mgr_ready),
        .mgr_beat  (mgr_beat),
        .fwd_ready (fwd_ready),
        .mgr_valid (mgr_valid)
    );

endmodule

// ==== rd_channel_mux_checker.sv ====
`timescale 1ns/1ps

module rd_channel_mux_checker (
    input logic                  clk,
    input logic                  rst,
    // registered flags inside the top level
    input rd_mux_pkg::pend_vec_t pending,
    input rd_mux_pkg::r_beat_t   sub_beat [rd_mux_pkg::NUM_PORT],
    input rd_mux_pkg::port_vec_t sub_valid,
    input rd_mux_pkg::port_vec_t sub_ready,
    input rd_mux_pkg::mgr_vec_t  mgr_valid
);

    import rd_mux_pkg::*;

    // failure count, picked up by the testbench at the end
    int unsigned assert_fails = 0;

    // a beat goes to one manager at most
    a_mgr_valid_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0(mgr_valid))
        else begin
            assert_fails++;
            $error("mgr_valid raised toward both managers");
        end

    // ready only ever goes back to the selected port
    a_sub_ready_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0(sub_ready))
        else begin
            assert_fails++;
            $error("sub_ready high on more than one port");
        end

    // flag drops only after a last beat from that subordinate went through
    for (genvar i = 0; i < NUM_SUB; i++) begin : g_flag
        a_flag_clear: assert property (@(posedge clk) disable iff (rst)
            $past(pending[i]) && !pending[i]
            |-> $past(sub_valid[i] && sub_ready[i] && sub_beat[i].last))
            else begin
                assert_fails++;
                $error("pending flag %0d cleared without a completed last beat", i);
            end
    end

endmodule

bind rd_channel_mux rd_channel_mux_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .pending   (pending),
    .sub_beat  (sub_beat),
    .sub_valid (sub_valid),
    .sub_ready (sub_ready),
    .mgr_valid (mgr_valid)
);

// ==== tb_rd_channel_mux.sv ====
`timescale 1ns/1ps

module tb_rd_channel_mux;

    import rd_mux_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 3;
    localparam int MAX_VEC = 128;
    // numeric columns that follow the tag on each line
    localparam int NUM_COLS = 22;
    localparam string TESTDATA_FILE = "rd_mux_testdata.txt";

    // one line of the data file
    typedef struct packed {
        pend_vec_t              ar_valid;
        port_vec_t              sub_valid;
        port_vec_t              last;
        sub_id_t [NUM_PORT-1:0] id;
        data_t                  base;
        mgr_vec_t               mgr_ready;
        mgr_vec_t               exp_valid;
        mgr_id_t                exp_id;
        data_t                  exp_data;
        port_vec_t              exp_ready;
    } vec_t;

    logic      clk;
    logic      rst;
    pend_vec_t ar_valid;
    r_beat_t   sub_beat [NUM_PORT];
    port_vec_t sub_valid;
    port_vec_t sub_ready;
    m_beat_t   mgr_beat;
    mgr_vec_t  mgr_valid;
    mgr_vec_t  mgr_ready;

    vec_t      vecs [MAX_VEC];
    string     tags [MAX_VEC];
    int        num_vec = 0;
    int        vec_idx;
    // lets the watchdog start once the length of the run is known
    logic      loaded = 1'b0;

    // error counts per kind of result
    int        valid_errors = 0;
    int        ready_errors = 0;
    int        beat_errors = 0;
    int        other_errors = 0;
    int        assert_errors = 0;

    rd_channel_mux u_dut (
        .clk       (clk),
        .rst       (rst),
        .ar_valid  (ar_valid),
        .sub_beat  (sub_beat),
        .sub_valid (sub_valid),
        .sub_ready (sub_ready),
        .mgr_beat  (mgr_beat),
        .mgr_valid (mgr_valid),
        .mgr_ready (mgr_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // read every vector line, lines starting with # are skipped
    task automatic load_vectors();
        int          fd;
        int          code;
        int          p;
        string       tag;
        string       line;
        logic [31:0] col [NUM_COLS];
        vec_t        v;
        fd = $fopen(TESTDATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", TESTDATA_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag.getc(0) == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                col[0], col[1], col[2], col[3], col[4], col[5],
                col[6], col[7], col[8], col[9], col[10], col[11],
                col[12], col[13], col[14], col[15], col[16], col[17],
                col[18], col[19], col[20], col[21]);
            if (code != NUM_COLS) begin
                $display("vector line %0d (%s) has missing or bad columns", num_vec, tag);
                other_errors++;
                break;
            end
            v.ar_valid  = col[0][NUM_SUB-1:0];
            v.sub_valid = col[1][NUM_PORT-1:0];
            // last bit and id come in pairs, port 0 first
            for (p = 0; p < NUM_PORT; p++) begin
                v.last[p] = col[2 + 2 * p][0];
                v.id[p]   = col[3 + 2 * p][SUB_ID_W-1:0];
            end
            v.base      = col[16];
            v.mgr_ready = col[17][NUM_MGR-1:0];
            v.exp_valid = col[18][NUM_MGR-1:0];
            v.exp_id    = col[19][MGR_ID_W-1:0];
            v.exp_data  = col[20];
            v.exp_ready = col[21][NUM_PORT-1:0];
            tags[num_vec] = tag;
            vecs[num_vec] = v;
            num_vec++;
        end
        $fclose(fd);
    endtask

    // each port gets base plus its index as data, resp is the low index bits
    task automatic drive_vector(input vec_t v);
        r_beat_t beat;
        int      p;
        ar_valid  <= v.ar_valid;
        sub_valid <= v.sub_valid;
        mgr_ready <= v.mgr_ready;
        for (p = 0; p < NUM_PORT; p++) begin
            beat.id   = v.id[p];
            beat.data = v.base + data_t'(p);
            beat.resp = resp_t'(p);
            beat.last = v.last[p];
            sub_beat[p] <= beat;
        end
    endtask

    // forwarded port recovered from the expected data offset
    function automatic m_beat_t expected_beat(input vec_t v);
        m_beat_t b;
        int      port;
        port   = int'(v.exp_data - v.base);
        b.id   = v.exp_id;
        b.data = v.exp_data;
        b.resp = resp_t'(port);
        b.last = (port >= 0 && port < NUM_PORT) ? v.last[port] : 1'b0;
        return b;
    endfunction

    task automatic check_mgr_vec(input string tag, input mgr_vec_t exp, input mgr_vec_t act);
        if (act !== exp) begin
            $display("Fail %s mgr_valid expected %b actual %b", tag, exp, act);
            valid_errors++;
        end
    endtask

    task automatic check_port_vec(input string tag, input port_vec_t exp, input port_vec_t act);
        if (act !== exp) begin
            $display("Fail %s sub_ready expected %b actual %b", tag, exp, act);
            ready_errors++;
        end
    endtask

    task automatic check_m_beat(input string tag, input m_beat_t exp, input m_beat_t act);
        if (act !== exp) begin
            $display("Fail %s mgr_beat", tag,
                " expected id %h data %h resp %b last %b", exp.id, exp.data, exp.resp, exp.last,
                " actual id %h data %h resp %b last %b", act.id, act.data, act.resp, act.last);
            beat_errors++;
        end
    endtask

    // run length follows the vector count, with margin for reset
    initial begin
        wait (loaded);
        #((num_vec + 10) * CLK_PERIOD);
        $display("the run timed out before all vectors were applied");
        $display("test failed");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        ar_valid  = '0;
        sub_valid = '0;
        mgr_ready = '0;
        for (vec_idx = 0; vec_idx < NUM_PORT; vec_idx++) begin
            sub_beat[vec_idx] = '0;
        end
        load_vectors();
        if (num_vec == 0) begin
            $display("no vectors were read from %s", TESTDATA_FILE);
            other_errors++;
        end else begin
            loaded = 1'b1;
            repeat (RST_CYCLES) @(posedge clk);
            rst <= 1'b0;
            for (vec_idx = 0; vec_idx < num_vec; vec_idx++) begin
                @(posedge clk);
                drive_vector(vecs[vec_idx]);
                // outputs settle well before the falling edge
                @(negedge clk);
                check_mgr_vec(tags[vec_idx], vecs[vec_idx].exp_valid, mgr_valid);
                check_port_vec(tags[vec_idx], vecs[vec_idx].exp_ready, sub_ready);
                if (vecs[vec_idx].exp_valid != '0) begin
                    check_m_beat(tags[vec_idx], expected_beat(vecs[vec_idx]), mgr_beat);
                end
            end
            // one more edge so the checker sees the last vector
            repeat (2) @(negedge clk);
        end
        assert_errors = u_dut.u_checker.assert_fails;
        $display("vectors %0d, mgr_valid errors %0d, sub_ready errors %0d, beat errors %0d, %s",
            num_vec, valid_errors, ready_errors, beat_errors,
            $sformatf("assertion errors %0d, other errors %0d", assert_errors, other_errors));
        if (valid_errors + ready_errors + beat_errors + assert_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== rd_mux_testdata.txt ====
# tag ar_valid sub_valid, then last and id for ports 0..6, base mgr_ready
# then expected mgr_valid mgr_id mgr_data sub_ready, all hex, beat data = base + port
reset    00 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
reset    00 00  0 00 0 00 0 00 0 00 0 00 0 00 0 15  00000000 1  0 0 00000000 40
reset    00 00  0 00 0 00 0 00 0 00 0 00 0 00 0 15  00000000 2  0 0 00000000 00
route_m0 01 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
route_m0 00 01  1 1a 0 00 0 00 0 00 0 00 0 00 0 00  00001000 1  1 a 00001000 01
route_m1 01 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
route_m1 00 01  1 2b 0 00 0 00 0 00 0 00 0 00 0 00  00002000 2  2 b 00002000 01
prio     09 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
prio     00 09  1 11 0 00 0 00 1 13 0 00 0 00 0 00  00003000 1  1 3 00003003 08
prio     00 01  1 11 0 00 0 00 0 00 0 00 0 00 0 00  00003000 1  1 1 00003000 01
burst    12 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
burst    00 12  0 00 0 21 0 00 0 00 1 14 0 00 0 00  00004000 3  2 1 00004001 02
burst    00 12  0 00 0 21 0 00 0 00 1 14 0 00 0 00  00004000 1  2 1 00004001 00
burst    00 12  0 00 0 21 0 00 0 00 1 14 0 00 0 00  00004000 0  2 1 00004001 00
burst    00 12  0 00 0 21 0 00 0 00 1 14 0 00 0 00  00004100 2  2 1 00004101 02
burst    00 12  0 00 1 21 0 00 0 00 1 14 0 00 0 00  00004200 2  2 1 00004201 02
burst    00 10  0 00 0 00 0 00 0 00 1 14 0 00 0 00  00004300 2  1 4 00004304 00
burst    00 10  0 00 0 00 0 00 0 00 1 14 0 00 0 00  00004300 1  1 4 00004304 10
set_clr  04 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
set_clr  04 04  0 00 0 00 1 12 0 00 0 00 0 00 0 00  00005000 1  1 2 00005002 04
set_clr  00 04  0 00 0 00 1 12 0 00 0 00 0 00 0 00  00005100 1  1 2 00005102 04
fallback 00 40  0 00 0 00 0 00 0 00 0 00 0 00 1 16  00005200 1  1 6 00005206 40
fallback 00 40  0 00 0 00 0 00 0 00 0 00 0 00 0 27  00006000 2  2 7 00006006 40
unmatch  00 40  0 00 0 00 0 00 0 00 0 00 0 00 1 08  00006100 3  0 0 00000000 00
unmatch  00 40  0 00 0 00 0 00 0 00 0 00 0 00 1 3c  00006100 3  0 0 00000000 00
unmatch  20 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
unmatch  00 20  0 00 0 00 0 00 0 00 0 00 1 35 0 00  00006200 3  0 0 00000000 00
unmatch  00 20  0 00 0 00 0 00 0 00 0 00 1 05 0 00  00006200 3  0 0 00000000 00
unmatch  00 20  0 00 0 00 0 00 0 00 0 00 1 15 0 00  00006300 1  1 5 00006305 20
idle     00 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 3  0 0 00000000 00
prio3    25 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
prio3    00 25  1 10 0 00 1 22 0 00 0 00 1 15 0 00  00007000 3  2 2 00007002 04
prio3    00 21  1 10 0 00 0 00 0 00 0 00 1 15 0 00  00007100 3  1 0 00007100 01
prio3    00 20  0 00 0 00 0 00 0 00 0 00 1 15 0 00  00007200 3  1 5 00007205 20
idle     00 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 3  0 0 00000000 00
novalid  08 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00
novalid  00 00  0 00 0 00 0 00 1 13 0 00 0 00 0 00  00008000 1  0 0 00000000 08
novalid  00 08  0 00 0 00 0 00 1 13 0 00 0 00 0 00  00008100 1  1 3 00008103 08
idle     00 00  0 00 0 00 0 00 0 00 0 00 0 00 0 00  00000000 0  0 0 00000000 00

// ==== rd_channel_mux.f ====
rd_mux_pkg.sv
rd_pending_track.sv
rd_sub_select.sv
rd_mgr_route.sv
rd_channel_mux.sv
rd_channel_mux_checker.sv
tb_rd_channel_mux.sv

// ==== Bender.yml ====
package:
  name: rd_channel_mux

sources:
  # design, in compile order
  - files:
      - rd_mux_pkg.sv
      - rd_pending_track.sv
      - rd_sub_select.sv
      - rd_mgr_route.sv
      - rd_channel_mux.sv

  # checker and testbench
  - target: test
    files:
      - rd_channel_mux_checker.sv
      - tb_rd_channel_mux.sv
